// ==== common/btb_cfg.svh ====
//##############################
// BTB geometry and field widths
// Include wherever array sizes are needed
//##############################
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// Set count and matching index width
`define BTB_SETS  512
`define BTB_IDX_W 9

// Stored tag, partial compare only
`define BTB_TAG_W 10

// Low bits of the branch target
`define BTB_TGT_W 16

// Associativity
`define BTB_WAYS  4
`define BTB_WAY_W 2

`endif

// ==== common/btb_entry_pkg.sv ====
//##############################
// Types of stored BTB contents
//##############################
`include "btb_cfg.svh"

package btb_entry_pkg;

  // One way's tag slot
  typedef struct packed {
    logic                  valid;
    logic [`BTB_TAG_W-1:0] tag;
  } btb_tag_half_t;

  localparam int TAG_HALF_W = $bits(btb_tag_half_t);

  // RAM word of a tag bank, even way in the low half
  typedef btb_tag_half_t [1:0] btb_tag_bank_t;

  localparam int TAG_BANK_W = $bits(btb_tag_bank_t);

  // Both banks together, way 0 lowest
  typedef btb_tag_half_t [`BTB_WAYS-1:0] btb_tag_row_t;

  // Target slot and full target row
  typedef logic [`BTB_TGT_W-1:0] btb_tgt_t;
  typedef btb_tgt_t [`BTB_WAYS-1:0] btb_tgt_row_t;

  localparam int TGT_ROW_W = $bits(btb_tgt_row_t);

endpackage

// ==== common/btb_req_pkg.sv ====
//##############################
// Request and response at the BTB port
//##############################
`include "btb_cfg.svh"

package btb_req_pkg;

  // Fetch side operations
  typedef enum logic [1:0] {
    BTB_NOP    = 2'd0,
    BTB_LOOKUP = 2'd1,
    BTB_UPDATE = 2'd2,
    BTB_INVAL  = 2'd3
  } btb_op_e;

  // One request per cycle, NOP when idle
  typedef struct packed {
    btb_op_e               op;
    logic [`BTB_IDX_W-1:0] index;
    logic [`BTB_TAG_W-1:0] tag;
    logic [`BTB_WAY_W-1:0] way;
    logic [`BTB_TGT_W-1:0] target;
  } btb_req_t;

  // Lookup result, one cycle after the lookup
  typedef struct packed {
    logic                  valid;
    logic                  hit;
    logic [`BTB_WAY_W-1:0] way;
    logic [`BTB_TGT_W-1:0] target;
  } btb_resp_t;

endpackage

// ==== rtl/gated_clk_cell.sv ====
//##############################
// Latch based clock gate
//##############################
`timescale 1ns/1ps

module gated_clk_cell (
  input  logic clk_in,
  input  logic global_en,
  input  logic module_en,
  input  logic local_en,
  input  logic pad_yy_icg_scan_en,
  output logic clk_out
);

  logic func_en;
  logic en_lat;

  // All three functional enables needed
  assign func_en = global_en & module_en & local_en;

  // Transparent in the low phase, so the enable is stable while clock is high
  always_latch begin
    if (!clk_in) begin
      // Scan forces the clock through
      en_lat <= func_en | pad_yy_icg_scan_en;
    end
  end

  assign clk_out = clk_in & en_lat;

endmodule

// ==== rtl/sram_sp.sv ====
//##############################
// Single port sync RAM model
// Active low strobes, bit write mask
//##############################
`timescale 1ns/1ps

module sram_sp #(
  parameter int DEPTH = 512,
  parameter int WIDTH = 22
) (
  input  logic                     clk,
  input  logic                     cen_b,
  input  logic                     gwen_b,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         bwen_b,
  input  logic [WIDTH-1:0]         din,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (!cen_b) begin
      if (!gwen_b) begin
        // Masked bits keep their old value
        mem[addr] <= (mem[addr] & bwen_b) | (din & ~bwen_b);
      end else begin
        dout <= mem[addr];
      end
    end
  end
  // Output holds across writes and idle cycles

  // Address must be clean whenever the macro is selected
  a_addr_known: assert property (
    @(posedge clk) !cen_b |-> !$isunknown(addr)
  );

endmodule

// ==== btb/btb_tag_array.sv ====
//##############################
// BTB tag storage, two banks of two ways
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_tag_array
  import btb_entry_pkg::*;
(
  input  logic                  btb_tag_clk,
  input  logic [`BTB_IDX_W-1:0] btb_index,
  input  logic                  btb_tag_cen_b,
  input  logic [`BTB_WAYS-1:0]  btb_tag_wen,
  input  btb_tag_half_t         btb_tag_din,
  output btb_tag_row_t          btb_tag_dout
);

  btb_tag_bank_t bank_din;

  // Same half entry offered to both slots, mask picks the way
  assign bank_din = {btb_tag_din, btb_tag_din};

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [1:0]            way_we;
    logic [TAG_BANK_W-1:0] bwen_b;
    logic                  gwen_b;
    btb_tag_bank_t         bank_q;

    // Ways 2b and 2b+1 live here
    assign way_we = btb_tag_wen[2*b +: 2];

    // Bit enables, active low
    assign bwen_b = ~{{TAG_HALF_W{way_we[1]}}, {TAG_HALF_W{way_we[0]}}};
    // Bank writes if either of its ways does
    assign gwen_b = ~(way_we[1] | way_we[0]);

    sram_sp #(
      .DEPTH (`BTB_SETS),
      .WIDTH (TAG_BANK_W)
    ) x_tag_bank (
      .clk    (btb_tag_clk  ),
      .cen_b  (btb_tag_cen_b),
      .gwen_b (gwen_b       ),
      .addr   (btb_index    ),
      .bwen_b (bwen_b       ),
      .din    (bank_din     ),
      .dout   (bank_q       )
    );

    assign btb_tag_dout[2*b +: 2] = bank_q;
  end

endmodule

// ==== btb/btb_target_array.sv ====
//##############################
// BTB target storage, all ways in one word
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_target_array
  import btb_entry_pkg::*;
(
  input  logic                  btb_tgt_clk,
  input  logic [`BTB_IDX_W-1:0] btb_index,
  input  logic                  btb_tgt_cen_b,
  input  logic [`BTB_WAYS-1:0]  btb_tgt_wen,
  input  btb_tgt_row_t          btb_tgt_din,
  output btb_tgt_row_t          btb_tgt_dout
);

  logic [TGT_ROW_W-1:0] bwen_b;
  logic                 gwen_b;

  // One enable per way fans out over its target bits
  for (genvar w = 0; w < `BTB_WAYS; w++) begin : g_way_mask
    assign bwen_b[w*`BTB_TGT_W +: `BTB_TGT_W] = {`BTB_TGT_W{~btb_tgt_wen[w]}};
  end

  // Read when no way is written
  assign gwen_b = ~|btb_tgt_wen;

  sram_sp #(
    .DEPTH (`BTB_SETS),
    .WIDTH (TGT_ROW_W)
  ) x_tgt_ram (
    .clk    (btb_tgt_clk  ),
    .cen_b  (btb_tgt_cen_b),
    .gwen_b (gwen_b       ),
    .addr   (btb_index    ),
    .bwen_b (bwen_b       ),
    .din    (btb_tgt_din  ),
    .dout   (btb_tgt_dout )
  );

endmodule

// ==== btb/btb_access_ctrl.sv ====
//##############################
// Request decode into array strobes
// Holds the lookup tag for the compare
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_access_ctrl
  import btb_entry_pkg::*, btb_req_pkg::*;
(
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  btb_req_t             req,
  output logic                 tag_cen_b,
  output logic [`BTB_WAYS-1:0] tag_wen,
  output btb_tag_half_t        tag_din,
  output logic [`BTB_WAYS-1:0] tgt_wen,
  output btb_tgt_row_t         tgt_din,
  output logic                 clk_en,
  output btb_req_t             lk_pend
);

  logic     pend_q;
  btb_req_t req_q;

  // Any real operation selects and clocks the arrays
  assign tag_cen_b = (req.op == BTB_NOP);
  assign clk_en    = (req.op != BTB_NOP);

  always_comb begin
    tag_wen       = '0;
    tgt_wen       = '0;
    tag_din.tag   = req.tag;
    tag_din.valid = 1'b0;
    case (req.op)
      BTB_UPDATE: begin
        tag_wen[req.way] = 1'b1;
        tgt_wen[req.way] = 1'b1;
        tag_din.valid    = 1'b1;
      end
      // Clear valid, target left alone
      BTB_INVAL: tag_wen[req.way] = 1'b1;
      default: ;
    endcase
  end

  // Target in every slot, way mask selects one
  assign tgt_din = {`BTB_WAYS{req.target}};

  // Lookup in flight
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= (req.op == BTB_LOOKUP);
    end
  end

  // Tag for next cycle compare
  always_ff @(posedge forever_cpuclk) begin
    req_q <= req;
  end

  always_comb begin
    lk_pend    = req_q;
    lk_pend.op = pend_q ? BTB_LOOKUP : BTB_NOP;
  end

  // Target writes only alongside a tag write of the same way
  a_tgt_with_tag: assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    (tgt_wen & ~tag_wen) == '0
  );

endmodule

// ==== btb/btb_hit_select.sv ====
//##############################
// Tag compare and way select
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_hit_select
  import btb_entry_pkg::*, btb_req_pkg::*;
(
  input  logic         forever_cpuclk,
  input  logic         rst,
  input  btb_req_t     lk_pend,
  input  btb_tag_row_t tag_row,
  input  btb_tgt_row_t tgt_row,
  output btb_resp_t    resp
);

  logic                 pend;
  logic [`BTB_WAYS-1:0] match;

  assign pend = (lk_pend.op == BTB_LOOKUP);

  // Idle cycles leave stale rows on the RAM outputs, so no match then
  always_comb begin
    for (int w = 0; w < `BTB_WAYS; w++) begin
      match[w] = pend && tag_row[w].valid && (tag_row[w].tag == lk_pend.tag);
    end
  end

  always_comb begin
    resp        = '0;
    resp.valid  = pend;
    // Walk down so the lowest matching way is the last one taken
    for (int w = `BTB_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        resp.hit    = 1'b1;
        resp.way    = `BTB_WAY_W'(w);
        resp.target = tgt_row[w];
      end
    end
  end

  // No hit without a lookup behind it
  a_hit_needs_valid: assert property (
    @(posedge forever_cpuclk) disable iff (rst)
    resp.hit |-> resp.valid
  );

endmodule

// ==== rtl/btb_top.sv ====
//##############################
// BTB top, fetch side request in
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_top
  import btb_entry_pkg::*, btb_req_pkg::*;
(
  input  logic      forever_cpuclk,
  input  logic      rst,
  input  logic      cp0_yy_clk_en,
  input  logic      cp0_ifu_icg_en,
  input  logic      pad_yy_icg_scan_en,
  input  btb_req_t  req,
  output btb_resp_t resp
);

  logic                 tag_cen_b;
  logic [`BTB_WAYS-1:0] tag_wen;
  btb_tag_half_t        tag_din;
  logic [`BTB_WAYS-1:0] tgt_wen;
  btb_tgt_row_t         tgt_din;
  logic                 clk_en;
  btb_req_t             lk_pend;
  logic                 btb_clk;
  btb_tag_row_t         tag_row;
  btb_tgt_row_t         tgt_row;

  btb_access_ctrl x_access_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst           ),
    .req            (req           ),
    .tag_cen_b      (tag_cen_b     ),
    .tag_wen        (tag_wen       ),
    .tag_din        (tag_din       ),
    .tgt_wen        (tgt_wen       ),
    .tgt_din        (tgt_din       ),
    .clk_en         (clk_en        ),
    .lk_pend        (lk_pend       )
  );

  // One gated clock for both arrays
  gated_clk_cell x_btb_clk_gate (
    .clk_in             (forever_cpuclk    ),
    .global_en          (cp0_yy_clk_en     ),
    .module_en          (cp0_ifu_icg_en    ),
    .local_en           (clk_en            ),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (btb_clk           )
  );

  btb_tag_array x_tag_array (
    .btb_tag_clk   (btb_clk  ),
    .btb_index     (req.index),
    .btb_tag_cen_b (tag_cen_b),
    .btb_tag_wen   (tag_wen  ),
    .btb_tag_din   (tag_din  ),
    .btb_tag_dout  (tag_row  )
  );

  // Same chip select as the tag side
  btb_target_array x_target_array (
    .btb_tgt_clk   (btb_clk  ),
    .btb_index     (req.index),
    .btb_tgt_cen_b (tag_cen_b),
    .btb_tgt_wen   (tgt_wen  ),
    .btb_tgt_din   (tgt_din  ),
    .btb_tgt_dout  (tgt_row  )
  );

  btb_hit_select x_hit_select (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst           ),
    .lk_pend        (lk_pend       ),
    .tag_row        (tag_row       ),
    .tgt_row        (tgt_row       ),
    .resp           (resp          )
  );

endmodule

// ==== dv/btb_tb.sv ====
//##############################
// BTB testbench, table of ops and expected responses
// Run through build.f, top module btb_tb
//##############################
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_tb
  import btb_req_pkg::*;
();

  localparam int HALF_PERIOD = 2;
  localparam int RST_CYCLES  = 3;
  localparam int SEED        = 28;

  // One table row, request plus what the response must be
  typedef struct packed {
    btb_req_t              req;
    logic                  gclk_en;
    logic                  exp_hit;
    logic [`BTB_WAY_W-1:0] exp_way;
    logic [`BTB_TGT_W-1:0] exp_tgt;
  } tbl_row_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      cp0_yy_clk_en;
  logic      cp0_ifu_icg_en;
  logic      pad_yy_icg_scan_en;
  btb_req_t  req;
  btb_resp_t resp;

  tbl_row_t              tbl[$];
  logic                  tbl_built = 1'b0;
  int                    err_cnt = 0;
  int unsigned           seed_ret;
  logic [`BTB_IDX_W-1:0] set_a, set_b, set_c;
  logic [`BTB_TAG_W-1:0] tag_a, tag_b, tag_c;
  logic [`BTB_TGT_W-1:0] tgt_0, tgt_1, tgt_2, tgt_3;

  btb_top uut (
    .forever_cpuclk     (clk               ),
    .rst                (rst               ),
    .cp0_yy_clk_en      (cp0_yy_clk_en     ),
    .cp0_ifu_icg_en     (cp0_ifu_icg_en    ),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .req                (req               ),
    .resp               (resp              )
  );

  always #HALF_PERIOD clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Update or invalidate, no response expected
  task automatic add_write(input btb_op_e op, input logic [`BTB_IDX_W-1:0] idx,
                           input logic [`BTB_TAG_W-1:0] tag, input int way,
                           input logic [`BTB_TGT_W-1:0] tgt, input logic en);
    tbl_row_t row;
    row         = '0;
    row.req     = '{op: op, index: idx, tag: tag, way: `BTB_WAY_W'(way), target: tgt};
    row.gclk_en = en;
    tbl.push_back(row);
  endtask

  // Miss rows carry way 0 and target 0
  task automatic add_lookup(input logic [`BTB_IDX_W-1:0] idx, input logic [`BTB_TAG_W-1:0] tag,
                            input logic hit, input int way, input logic [`BTB_TGT_W-1:0] tgt);
    tbl_row_t row;
    row         = '0;
    row.req     = '{op: BTB_LOOKUP, index: idx, tag: tag, way: '0, target: '0};
    row.gclk_en = 1'b1;
    row.exp_hit = hit;
    row.exp_way = `BTB_WAY_W'(way);
    row.exp_tgt = tgt;
    tbl.push_back(row);
  endtask

  task automatic build_table();
    // RAM starts undefined, clear every set in use
    for (int w = 0; w < `BTB_WAYS; w++) begin
      add_write(BTB_INVAL, set_a, tag_a, w, tgt_0, 1'b1);
      add_write(BTB_INVAL, set_b, tag_a, w, tgt_0, 1'b1);
      add_write(BTB_INVAL, set_c, tag_a, w, tgt_0, 1'b1);
    end
    add_lookup(set_a, tag_a, 1'b0, 0, '0);
    // Way 2 sits in the upper bank
    add_write(BTB_UPDATE, set_a, tag_a, 2, tgt_0, 1'b1);
    add_lookup(set_a, tag_a, 1'b1, 2, tgt_0);
    // Same tag in ways 1 and 3, lowest wins
    add_write(BTB_UPDATE, set_a, tag_b, 1, tgt_1, 1'b1);
    add_write(BTB_UPDATE, set_a, tag_b, 3, tgt_3, 1'b1);
    add_lookup(set_a, tag_b, 1'b1, 1, tgt_1);
    add_write(BTB_INVAL, set_a, tag_b, 1, tgt_0, 1'b1);
    add_lookup(set_a, tag_b, 1'b1, 3, tgt_3);
    add_lookup(set_a, tag_a, 1'b1, 2, tgt_0);
    // Idle cycle gives no response
    add_write(BTB_NOP, set_a, tag_a, 0, tgt_0, 1'b1);
    // Other tag, adjacent set, then back to back lookups
    add_lookup(set_a, tag_c, 1'b0, 0, '0);
    add_lookup(set_b, tag_a, 1'b0, 0, '0);
    add_lookup(set_a, tag_a, 1'b1, 2, tgt_0);
    add_lookup(set_a, tag_b, 1'b1, 3, tgt_3);
    add_lookup(set_b, tag_b, 1'b0, 0, '0);
    // Global enable low, update is lost
    add_write(BTB_UPDATE, set_c, tag_a, 0, tgt_2, 1'b0);
    add_lookup(set_c, tag_a, 1'b0, 0, '0);
    add_write(BTB_UPDATE, set_c, tag_a, 0, tgt_2, 1'b1);
    add_lookup(set_c, tag_a, 1'b1, 0, tgt_2);
  endtask

  task automatic check_resp(input int idx);
    tbl_row_t row;
    row = tbl[idx];
    compare_value($sformatf("resp.valid row %0d", idx), 32'(resp.valid),
                  32'(row.req.op == BTB_LOOKUP));
    compare_value($sformatf("resp.hit row %0d", idx), 32'(resp.hit), 32'(row.exp_hit));
    compare_value($sformatf("resp.way row %0d", idx), 32'(resp.way), 32'(row.exp_way));
    compare_value($sformatf("resp.target row %0d", idx), 32'(resp.target), 32'(row.exp_tgt));
  endtask

  initial begin
    rst                = 1'b1;
    // Lookup held through reset, must not leave a response pending
    req                = '0;
    req.op             = BTB_LOOKUP;
    cp0_yy_clk_en      = 1'b1;
    cp0_ifu_icg_en     = 1'b1;
    pad_yy_icg_scan_en = 1'b0;
    seed_ret = $urandom(SEED);
    set_a = `BTB_IDX_W'($urandom());
    set_b = set_a + `BTB_IDX_W'(1);
    set_c = set_a ^ `BTB_IDX_W'('h100);
    tag_a = `BTB_TAG_W'($urandom());
    // Fixed XOR keeps the three tags distinct
    tag_b = tag_a ^ `BTB_TAG_W'('h155);
    tag_c = tag_a ^ `BTB_TAG_W'('h2aa);
    tgt_0 = `BTB_TGT_W'($urandom());
    tgt_1 = `BTB_TGT_W'($urandom());
    tgt_2 = `BTB_TGT_W'($urandom());
    tgt_3 = `BTB_TGT_W'($urandom());
    build_table();
    tbl_built = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    req <= '0;
    @(negedge clk);
    compare_value("resp.valid after reset", 32'(resp.valid), 32'd0);
    // Row i goes out while row i-1 answers
    for (int i = 0; i <= tbl.size(); i++) begin
      @(posedge clk);
      if (i < tbl.size()) begin
        req           <= tbl[i].req;
        cp0_yy_clk_en <= tbl[i].gclk_en;
      end else begin
        req           <= '0;
        cp0_yy_clk_en <= 1'b1;
      end
      if (i > 0) begin
        @(negedge clk);
        check_resp(i - 1);
      end
    end
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog, four cycles per row plus reset
  initial begin
    wait (tbl_built);
    repeat (RST_CYCLES + 4 * tbl.size()) @(posedge clk);
    $display("Watchdog expired before the table was done");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

// ==== build.f ====
+incdir+common
common/btb_entry_pkg.sv
common/btb_req_pkg.sv
rtl/gated_clk_cell.sv
rtl/sram_sp.sv
btb/btb_tag_array.sv
btb/btb_target_array.sv
btb/btb_access_ctrl.sv
btb/btb_hit_select.sv
rtl/btb_top.sv
dv/btb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := btb_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(OBJ_DIR)/V%: $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
